//--- Bender.yml
package:
  name: aes_pipe

export_include_dirs:
  - design

sources:
  - files:
      - design/aes_pkg.sv
      - design/aes_gf_inv.sv
      - design/aes_sbox_word.sv
      - design/aes_round.sv
      - design/aes_round_stage.sv
      - design/aes_pipe.sv
  - target: simulation
    files:
      - tests/tb_clock.sv
      - tests/aes_pipe_chk.sv
      - tests/tb_aes_pipe.sv

//--- aes_pipe.f
+incdir+design
design/aes_pkg.sv
design/aes_gf_inv.sv
design/aes_sbox_word.sv
design/aes_round.sv
design/aes_round_stage.sv
design/aes_pipe.sv
tests/tb_clock.sv
tests/aes_pipe_chk.sv
tests/tb_aes_pipe.sv

//--- design/aes_cfg.svh
//--------------------------------------
// AES size configuration
// Block, column, byte and round counts
//--------------------------------------

`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// Data path widths
`define AES_BLOCK_W 128 // State and key width
`define AES_WORD_W  32  // One state column
`define AES_BYTE_W  8   // One field element

// Pipeline depth
`define AES_ROUNDS  10  // AES-128 round count, one stage each

`endif

//--- design/aes_gf_inv.sv
//--------------------------------------
// GF(2^8) multiplicative inverse
// Composite field GF(((2^2)^2)^2) tower
// lambda = 4'b1100, phi = 2'b10
//--------------------------------------

module aes_gf_inv
   import aes_pkg::*;
(
   input  byte_t x, // Field element, polynomial basis
   output byte_t y  // Inverse, 0 maps to 0
);

   //--------------------------------------
   // Basis change matrices, entry [i] is output bit i
   localparam logic [7:0][7:0] ISO = {
      8'b1010_0000, // Bit 7
      8'b1101_1110,
      8'b1010_1100,
      8'b1010_1110,
      8'b1100_0110,
      8'b1001_1110,
      8'b0101_0010,
      8'b0100_0011  // Bit 0
   };

   localparam logic [7:0][7:0] ISO_INV = {
      8'b1110_0010, // Bit 7
      8'b0100_0100,
      8'b0110_0010,
      8'b0111_0110,
      8'b0011_1110,
      8'b1001_1110,
      8'b0011_0000,
      8'b0111_0101  // Bit 0
   };

   byte_t xm;       // x in composite basis
   byte_t ym;       // Inverse in composite basis
   nib_t  hi, lo;   // Coefficients of the GF(2^4) pair
   nib_t  sum;      // hi + lo
   nib_t  norm;     // GF(2^4) norm
   nib_t  norm_inv; // Inverse of norm

   // GF(2) matrix times vector
   function automatic byte_t mat_mul(logic [7:0][7:0] m, byte_t v);
      byte_t r;
      for (int i = 0; i < 8; i++) begin
         r[i] = ^(m[i] & v); // Row parity
      end
      return r;
   endfunction

   // GF(2^4) inverse through one more tower level
   function automatic nib_t inv4(nib_t a);
      logic [1:0] s, n;
      s = a[3:2] ^ a[1:0];
      n = gf_inv2(gf_mul2_phi(gf_sq2(a[3:2])) ^ gf_mul2(s, a[1:0])); // GF(4) norm inverse
      return {gf_mul2(a[3:2], n), gf_mul2(s, n)};
   endfunction

   //--------------------------------------
   assign xm        = mat_mul(ISO, x);   // Into tower field
   assign {hi, lo}  = xm;
   assign sum       = hi ^ lo;
   assign norm      = gf_mul4_lambda(gf_sq4(hi)) ^ gf_mul4(sum, lo);
   assign norm_inv  = inv4(norm);
   assign ym        = {gf_mul4(hi, norm_inv), gf_mul4(sum, norm_inv)};
   assign y         = mat_mul(ISO_INV, ym); // Back to AES basis

endmodule

//--- design/aes_pipe.sv
//--------------------------------------
// AES-128 fully pipelined encryptor
// Whitening, then ten registered rounds
//--------------------------------------

`include "aes_cfg.svh"

module aes_pipe
   import aes_pkg::*;
(
   input  logic   CLK,
   input  logic   rst,  // Async, active high
   input  block_t Din,  // Plaintext
   input  block_t Kin,  // Cipher key for this block
   input  logic   Drdy, // Din and Kin valid strobe
   output block_t Dout, // Ciphertext
   output logic   Dvld  // Dout valid strobe
);

   stage_t pipe [`AES_ROUNDS+1]; // Stage 0 is combinational

   // Initial AddRoundKey with the cipher key
   assign pipe[0] = '{valid: Drdy, state: Din ^ Kin, rkey: Kin};

   for (genvar r = 1; r <= `AES_ROUNDS; r++) begin : g_stage
      aes_round_stage #(
         .ROUND (r)
      ) i_stage (
         .CLK  (CLK),
         .rst  (rst),
         .prev (pipe[r-1]),
         .next (pipe[r])
      );
   end

   assign Dout = pipe[`AES_ROUNDS].state; // Last stage register
   assign Dvld = pipe[`AES_ROUNDS].valid;

endmodule

//--- design/aes_pkg.sv
//--------------------------------------
// AES shared types and field helpers
// GF(2^8) doubling, round constants and
// the GF(2^4)/GF(2^2) composite arithmetic
//--------------------------------------

`include "aes_cfg.svh"

package aes_pkg;

   typedef logic [`AES_BLOCK_W-1:0] block_t; // State or round key
   typedef logic [`AES_WORD_W-1:0]  word_t;  // Column, MSB byte is row 0
   typedef logic [`AES_BYTE_W-1:0]  byte_t;  // GF(2^8) element
   typedef logic [3:0]              nib_t;   // GF(2^4) element

   // Payload handed from stage to stage
   typedef struct packed {
      logic   valid; // Block present
      block_t state; // Cipher state after this round
      block_t rkey;  // Round key used by this round
   } stage_t;

   //--------------------------------------
   // GF(2^2), basis as in the S-box tower
   function automatic logic [1:0] gf_mul2(logic [1:0] a, logic [1:0] b);
      logic hh;
      hh = a[1] & b[1];
      return {hh ^ (a[0] & b[1]) ^ (a[1] & b[0]), hh ^ (a[0] & b[0])};
   endfunction

   function automatic logic [1:0] gf_sq2(logic [1:0] a);
      return {a[1], a[1] ^ a[0]}; // Frobenius, linear
   endfunction

   function automatic logic [1:0] gf_mul2_phi(logic [1:0] a);
      return gf_mul2(a, 2'b10); // phi = 2'b10
   endfunction

   function automatic logic [1:0] gf_inv2(logic [1:0] a);
      return gf_sq2(a); // a^-1 == a^2 in GF(4), 0 stays 0
   endfunction

   //--------------------------------------
   // GF(2^4) over x^2 + x + phi
   function automatic nib_t gf_mul4(nib_t a, nib_t b);
      logic [1:0] hh, ll, ss;
      hh = gf_mul2(a[3:2], b[3:2]);                     // High product
      ll = gf_mul2(a[1:0], b[1:0]);                     // Low product
      ss = gf_mul2(a[3:2] ^ a[1:0], b[3:2] ^ b[1:0]);   // Karatsuba middle
      return {ss ^ ll, gf_mul2_phi(hh) ^ ll};
   endfunction

   function automatic nib_t gf_sq4(nib_t a);
      logic [1:0] s1;
      s1 = gf_sq2(a[3:2]);
      return {s1, gf_mul2_phi(s1) ^ gf_sq2(a[1:0])};
   endfunction

   function automatic nib_t gf_mul4_lambda(nib_t a);
      return gf_mul4(a, 4'b1100); // lambda = 4'b1100
   endfunction

   //--------------------------------------
   // GF(2^8) doubling, AES polynomial 0x11b
   function automatic byte_t xtime(byte_t a);
      return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
   endfunction

   // Round constant for rounds 1..10
   function automatic byte_t rcon_of(int unsigned round);
      byte_t rc;
      rc = 8'h01;
      for (int unsigned i = 1; i < round; i++) begin
         rc = xtime(rc); // Powers of x
      end
      return rc;
   endfunction

endpackage

//--- design/aes_round.sv
//--------------------------------------
// One AES encryption round, combinational
// SubBytes, ShiftRows, MixColumns, AddRoundKey
//--------------------------------------

`include "aes_cfg.svh"

module aes_round
   import aes_pkg::*;
#(
   parameter bit FINAL = 1'b0 // Last round skips MixColumns
) (
   input  block_t state_in,  // State entering the round
   input  block_t rkey,      // Round key for this round
   output block_t state_out  // State after AddRoundKey
);

   localparam int NC = `AES_BLOCK_W / `AES_WORD_W; // Columns
   localparam int BW = `AES_BYTE_W;

   word_t sub [NC]; // After SubBytes
   word_t shf [NC]; // After ShiftRows
   word_t mix [NC]; // After MixColumns

   // Column times the fixed {02,03,01,01} circulant
   function automatic word_t mix_col(word_t w);
      byte_t a [4];
      byte_t b [4];
      word_t r;
      for (int i = 0; i < 4; i++) begin
         a[i] = w[31-8*i -: 8];
         b[i] = xtime(a[i]); // 2 * a
      end
      for (int i = 0; i < 4; i++) begin
         r[31-8*i -: 8] = b[i] ^ b[(i+1)%4] ^ a[(i+1)%4] ^ a[(i+2)%4] ^ a[(i+3)%4];
      end
      return r;
   endfunction

   //--------------------------------------
   // Byte substitution, column 0 at the MSB end
   for (genvar c = 0; c < NC; c++) begin : g_col
      aes_sbox_word i_sbox (
         .x (state_in[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W]),
         .y (sub[c])
      );
   end

   always_comb begin
      for (int c = 0; c < NC; c++) begin
         for (int r = 0; r < 4; r++) begin
            shf[c][`AES_WORD_W-1-BW*r -: BW] = sub[(c+r)%NC][`AES_WORD_W-1-BW*r -: BW]; // Row r left by r
         end
         mix[c] = FINAL ? shf[c] : mix_col(shf[c]);
      end
   end

   assign state_out = {mix[0], mix[1], mix[2], mix[3]} ^ rkey; // AddRoundKey

endmodule

//--- design/aes_round_stage.sv
//--------------------------------------
// AES pipeline stage
// Expands its round key, runs one round,
// registers state, key and valid
//--------------------------------------

`include "aes_cfg.svh"

module aes_round_stage
   import aes_pkg::*;
#(
   parameter int ROUND = 1 // 1 .. AES_ROUNDS
) (
   input  logic   CLK,
   input  logic   rst,  // Async, active high
   input  stage_t prev, // From previous stage
   output stage_t next  // Registered result
);

   word_t  k [4];     // Previous round key words
   word_t  n [4];     // New round key words
   word_t  rot;       // RotWord of last key word
   word_t  sub;       // SubWord result
   word_t  tmp;       // SubWord ^ rcon
   block_t new_key;   // Round key ROUND
   block_t round_out; // Round result

   //--------------------------------------
   // Key schedule
   assign k[0] = prev.rkey[127:96];
   assign k[1] = prev.rkey[95:64];
   assign k[2] = prev.rkey[63:32];
   assign k[3] = prev.rkey[31:0];

   assign rot = {k[3][23:0], k[3][31:24]}; // Rotate left one byte

   aes_sbox_word i_subword (
      .x (rot),
      .y (sub)
   );

   assign tmp  = sub ^ {rcon_of(ROUND), 24'h0}; // rcon into top byte
   assign n[0] = k[0] ^ tmp;
   assign n[1] = k[1] ^ n[0]; // XOR chain
   assign n[2] = k[2] ^ n[1];
   assign n[3] = k[3] ^ n[2];

   assign new_key = {n[0], n[1], n[2], n[3]};

   //--------------------------------------
   // Round data path
   aes_round #(
      .FINAL (ROUND == `AES_ROUNDS)
   ) i_round (
      .state_in  (prev.state),
      .rkey      (new_key),
      .state_out (round_out)
   );

   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         next <= '0; // Empty stage
      end else begin
         next.valid <= prev.valid;
         next.state <= round_out;
         next.rkey  <= new_key; // Carried to next stage
      end
   end

endmodule

//--- design/aes_sbox_word.sv
//--------------------------------------
// AES S-box over one 32-bit column
// Field inverse plus affine map per byte
//--------------------------------------

`include "aes_cfg.svh"

module aes_sbox_word
   import aes_pkg::*;
(
   input  word_t x, // Four input bytes
   output word_t y  // Four substituted bytes
);

   localparam int NB = `AES_WORD_W / `AES_BYTE_W; // Bytes per word

   byte_t inv [NB]; // Inverted bytes

   // Affine map, b ^ rotations 1..4 ^ 0x63
   function automatic byte_t affine(byte_t b);
      return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^
             {b[3:0], b[7:4]} ^ 8'h63;
   endfunction

   for (genvar i = 0; i < NB; i++) begin : g_byte
      aes_gf_inv i_inv (
         .x (x[`AES_BYTE_W*i +: `AES_BYTE_W]),
         .y (inv[i])
      );
      assign y[`AES_BYTE_W*i +: `AES_BYTE_W] = affine(inv[i]); // Final S-box value
   end

endmodule

//--- tests/aes_pipe_chk.sv
//--------------------------------------
// AES pipeline checker
// Reset, latency and known-answer
// assertions, bound into aes_pipe
//--------------------------------------

`include "aes_cfg.svh"

module aes_pipe_chk
   import aes_pkg::*;
(
   input logic   CLK,
   input logic   rst,
   input block_t Din,
   input block_t Kin,
   input logic   Drdy,
   input block_t Dout,
   input logic   Dvld
);

   localparam int LAT  = `AES_ROUNDS; // Drdy to Dvld latency in clocks
   localparam int NKAT = 3;

   // FIPS-197 plaintext, key and ciphertext triples
   localparam block_t KAT_P [NKAT] = '{
      128'h00112233445566778899aabbccddeeff,
      128'h3243f6a8885a308d313198a2e0370734,
      128'h0
   };
   localparam block_t KAT_K [NKAT] = '{
      128'h000102030405060708090a0b0c0d0e0f,
      128'h2b7e151628aed2a6abf7158809cf4f3c,
      128'h0
   };
   localparam block_t KAT_C [NKAT] = '{
      128'h69c4e0d86a7b0430d8cdb78070b4c55a,
      128'h3925841d02dc09fbdc118597196a0b32,
      128'h66e94bd4ef8a2c3b884cfa59ca342b2e
   };

   logic   vld_h [LAT]; // Drdy history, [LAT-1] is oldest
   block_t din_h [LAT]; // Din history
   block_t kin_h [LAT]; // Kin history
   bit     fail_rst = 1'b0;
   bit     fail_vld = 1'b0;
   bit     fail_kat = 1'b0;
   logic   fail_any;    // Seen by the testbench

   // Table row of a known pair or -1
   function automatic int kat_idx(block_t p, block_t k);
      for (int i = 0; i < NKAT; i++) begin
         if (p == KAT_P[i] && k == KAT_K[i]) begin
            return i;
         end
      end
      return -1;
   endfunction

   //--------------------------------------
   // Input history cleared like the pipe
   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < LAT; i++) begin
            vld_h[i] <= 1'b0;
            din_h[i] <= '0;
            kin_h[i] <= '0;
         end
      end else begin
         vld_h[0] <= Drdy;
         din_h[0] <= Din;
         kin_h[0] <= Kin;
         for (int i = 1; i < LAT; i++) begin
            vld_h[i] <= vld_h[i-1]; // One slot per stage
            din_h[i] <= din_h[i-1];
            kin_h[i] <= kin_h[i-1];
         end
      end
   end

   assign fail_any = fail_rst | fail_vld | fail_kat;

   //--------------------------------------
   a_reset_dvld : assert property (@(posedge CLK) rst |-> !Dvld)
      else begin
         fail_rst = 1'b1;
         $error("FAILED at %0t: Dvld = %b, expected 0", $time, $sampled(Dvld));
      end

   a_reset_dout : assert property (@(posedge CLK) rst |-> Dout == '0)
      else begin
         fail_rst = 1'b1;
         $error("FAILED at %0t: Dout = %h, expected %h", $time, $sampled(Dout),
                128'h0);
      end

   a_latency : assert property (@(posedge CLK) disable iff (rst) Dvld == vld_h[LAT-1])
      else begin
         fail_vld = 1'b1;
         $error("FAILED at %0t: Dvld = %b, expected %b", $time, $sampled(Dvld),
                $sampled(vld_h[LAT-1]));
      end

   a_known_answer : assert property (@(posedge CLK) disable iff (rst)
      (Dvld && kat_idx(din_h[LAT-1], kin_h[LAT-1]) >= 0) |->
      Dout == KAT_C[kat_idx(din_h[LAT-1], kin_h[LAT-1])])
      else begin
         fail_kat = 1'b1;
         $error("FAILED at %0t: Dout = %h, expected %h", $time, $sampled(Dout),
                KAT_C[kat_idx($sampled(din_h[LAT-1]), $sampled(kin_h[LAT-1]))]);
      end

endmodule

bind aes_pipe aes_pipe_chk i_chk (
   .CLK  (CLK),
   .rst  (rst),
   .Din  (Din),
   .Kin  (Kin),
   .Drdy (Drdy),
   .Dout (Dout),
   .Dvld (Dvld)
);

//--- tests/tb_aes_pipe.sv
//--------------------------------------
// AES pipeline testbench
// Known-answer blocks, gaps with noise,
// back to back keys; checker does the checks
//--------------------------------------

module tb_aes_pipe
   import aes_pkg::*;
();

   localparam int MAX_CYCLES = 200; // Reset, ~50 stimulus, drain, margin
   localparam int DRV_DLY    = 5;   // Input skew after rising edge
   localparam int NKAT       = 3;

   localparam block_t KAT_P [NKAT] = '{
      128'h00112233445566778899aabbccddeeff,
      128'h3243f6a8885a308d313198a2e0370734,
      128'h0
   };
   localparam block_t KAT_K [NKAT] = '{
      128'h000102030405060708090a0b0c0d0e0f,
      128'h2b7e151628aed2a6abf7158809cf4f3c,
      128'h0
   };

   logic        CLK;
   logic        rst;
   block_t      Din;
   block_t      Kin;
   logic        Drdy;
   block_t      Dout;
   logic        Dvld;
   logic [31:0] rng = 32'd1623; // Noise generator state
   int          issued;         // Blocks sent
   int          received;       // Dvld pulses seen
   int          cycles = 0;

   tb_clock i_clock (
      .CLK (CLK),
      .rst (rst)
   );

   aes_pipe i_aes_pipe (
      .CLK  (CLK),
      .rst  (rst),
      .Din  (Din),
      .Kin  (Kin),
      .Drdy (Drdy),
      .Dout (Dout),
      .Dvld (Dvld)
   );

   function automatic logic [31:0] xorshift32(logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   //--------------------------------------
   // Advance one clock, count outputs at the drive point
   task automatic step();
      @(posedge CLK);
      #DRV_DLY;
      if (Dvld) begin
         received++;
      end
   endtask

   task automatic noise_block(output block_t b);
      for (int i = 0; i < 4; i++) begin
         rng = xorshift32(rng);
         b[32*i +: 32] = rng; // One word per draw
      end
   endtask

   task automatic send(block_t p, block_t k);
      Drdy = 1'b1;
      Din  = p;
      Kin  = k;
      issued++;
      step();
   endtask

   // Idle cycles with junk on the data inputs
   task automatic gap(int n);
      repeat (n) begin
         Drdy = 1'b0;
         noise_block(Din);
         noise_block(Kin);
         step();
      end
   endtask

   //--------------------------------------
   always @(posedge CLK) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: %0d cycles passed and %0d of %0d blocks came out",
                  cycles, received, issued);
         $display("Done: errors found");
         $fatal(1, "Run stopped on timeout");
      end
   end

   // First assertion failure ends the run
   initial begin
      wait (i_aes_pipe.i_chk.fail_any === 1'b1);
      $display("Done: errors found");
      $fatal(1, "Assertion failure in aes_pipe_chk");
   end

   initial begin
      Din      = '0;
      Kin      = '0;
      Drdy     = 1'b0;
      issued   = 0;
      received = 0;
      wait (rst === 1'b1);
      wait (rst === 1'b0);
      step();
      gap(3);
      send(KAT_P[0], KAT_K[0]); // Alone in the pipe
      gap(12);
      send(KAT_P[1], KAT_K[1]);
      gap(4);
      send(KAT_P[2], KAT_K[2]);
      gap(5);
      for (int i = 0; i < 12; i++) begin
         send(KAT_P[i % NKAT], KAT_K[i % NKAT]); // New key every cycle
      end
      gap(6);
      send(KAT_P[1], KAT_K[1]);
      send(KAT_P[0], KAT_K[0]);
      gap(2);
      send(KAT_P[2], KAT_K[2]);
      while (received < issued) begin
         gap(1); // Drain, timeout guards
      end
      gap(2);
      if (i_aes_pipe.i_chk.fail_any) begin
         $display("Done: errors found");
         $fatal(1, "Assertion failures recorded");
      end else begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

//--- tests/tb_clock.sv
//--------------------------------------
// Testbench clock and reset source
//--------------------------------------

module tb_clock (
   output logic CLK,
   output logic rst
);

   localparam int HALF_PERIOD = 20; // 40 unit period
   localparam int RST_CYCLES  = 8;  // Reset length in clocks

   initial begin
      CLK = 1'b0;
      forever #HALF_PERIOD CLK = ~CLK;
   end

   initial begin
      rst = 1'b0;
      #1 rst = 1'b1;                     // Clean rising edge for async clear
      repeat (RST_CYCLES) @(posedge CLK);
      #5 rst = 1'b0;                     // Release away from the edge
   end

endmodule
